// ==== shotsTop.f ====
+incdir+common
common/shotsPkg.sv
source/shotsRegs.sv
shots/shotObject.sv
shots/shotsMux.sv
source/shotsTop.sv
tests/shotsTopTb.sv

// ==== Bender.yml ====
package:
  name: shotsTop

sources:
  - include_dirs:
      - common
    files:
      - common/shotsPkg.sv
      - source/shotsRegs.sv
      - shots/shotObject.sv
      - shots/shotsMux.sv
      - source/shotsTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/shotsTopTb.sv

// ==== tests/shotsTopTb.sv ====
`include "shots_settings.svh"

module shotsTopTb;
	timeunit 1ns;
	timeprecision 1ps;

	import shotsPkg::*;

	typedef struct packed {
		logic valid;
		logic req;
		rgb_t rgb;
	} pixelExp_t;

	// every pixel scan of the tests plus up to 400 register accesses of two cycles
	localparam int SCAN_CYCLES = 16*24 + 12*16 + 6*8*28 + 4*250;
	localparam int BUS_CYCLES = 2*400;
	localparam int CYCLE_LIMIT = 2*(SCAN_CYCLES + BUS_CYCLES);

	logic	clk;
	logic	resetN;
	logic	wbCyc;
	logic	wbStb;
	logic	wbWe;
	logic	wbAck;
	logic	[`WB_ADR_BITS-1:0] wbAdr;
	logic	[`WB_DAT_BITS-1:0] wbDatIn;
	logic	[`WB_DAT_BITS-1:0] wbDatOut;
	coord_t	pixelX;
	coord_t	pixelY;
	logic	frameStart;
	logic	shotsDrawingRequest;
	rgb_t	shotsRGB;

	// reference copy of the shot registers
	coord_t	mX [`SHOT_COUNT];
	coord_t	mY [`SHOT_COUNT];
	rgb_t	mColor [`SHOT_COUNT];
	logic	mActive [`SHOT_COUNT];

	pixelExp_t	curExp = '0; // entry for the pixel now on the inputs
	pixelExp_t	expQ [$];
	string	testName = "reset";
	int	errorCount = 0;
	int	checkCount = 0;
	int	cycleCount = 0;
	logic	[31:0] lcgState = 32'hb264_3818;

	shotsTop dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function logic [15:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	// the lowest active index that covers the pixel wins
	function logic [8:0] expectPixel(input int px, input int py);
		for (int i = 0; i < `SHOT_COUNT; i++) begin
			if (mActive[i] && px >= mX[i] && px < mX[i] + `SHOT_WIDTH &&
					py >= mY[i] && py < mY[i] + `SHOT_HEIGHT)
				return {1'b1, mColor[i]};
		end
		return {1'b0, `TRANSPARENT_RGB};
	endfunction

	function logic [15:0] modelField(input int shot, input shotField_t field);
		case (field)
			FIELD_X:     return 16'(mX[shot]);
			FIELD_Y:     return 16'(mY[shot]);
			FIELD_COLOR: return 16'(mColor[shot]);
			default:     return 16'(mActive[shot]);
		endcase
	endfunction

	function void updateModel(input int shot, input shotField_t field, input logic [15:0] data);
		case (field)
			FIELD_X:     mX[shot] = data[9:0];
			FIELD_Y:     mY[shot] = data[9:0];
			FIELD_COLOR: mColor[shot] = data[7:0];
			default:     mActive[shot] = data[0];
		endcase
	endfunction

	// climb or retire every active shot but the one whose write wins
	function void applyMotion(input int skip);
		for (int i = 0; i < `SHOT_COUNT; i++) begin
			if (i != skip && mActive[i]) begin
				if (mY[i] >= `SHOT_SPEED)
					mY[i] = mY[i] - `SHOT_SPEED;
				else
					mActive[i] = 1'b0;
			end
		end
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic busAccess(input logic we, input int shot, input shotField_t field,
			input logic [15:0] wdata, input logic withFrame, output logic [15:0] rdata);
		int waits;
		@(negedge clk);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = `WB_ADR_BITS'(shot * 4 + int'(field));
		wbDatIn = wdata;
		frameStart = withFrame; // lands on the ack edge
		waits = 0;
		do begin
			@(negedge clk);
			frameStart = 1'b0;
			waits++;
		end while (!wbAck && waits < 4);
		if (!wbAck) begin
			errorCount++;
			$display("%s: no wbAck for shot %0d %s", testName, shot, field.name());
		end
		else if (waits != 1) begin
			errorCount++;
			$display("%s: wbAck came %0d cycles late", testName, waits - 1);
		end
		rdata = wbDatOut;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbWrite(input int shot, input shotField_t field, input logic [15:0] data);
		logic [15:0] ignored;
		busAccess(1'b1, shot, field, data, 1'b0, ignored);
		updateModel(shot, field, data);
	endtask

	task automatic wbRead(input int shot, input shotField_t field, output logic [15:0] data);
		busAccess(1'b0, shot, field, 16'h0000, 1'b0, data);
	endtask

	task automatic readCheck(input int shot, input shotField_t field);
		logic [15:0] data;
		wbRead(shot, field, data);
		checkValue($sformatf("%s read shot %0d %s", testName, shot, field.name()),
			32'(modelField(shot, field)), 32'(data));
	endtask

	task automatic framePulse();
		@(negedge clk);
		frameStart = 1'b1;
		@(negedge clk);
		frameStart = 1'b0;
		applyMotion(-1);
	endtask

	task automatic frameWithWrite(input int shot, input shotField_t field,
			input logic [15:0] data);
		logic [15:0] ignored;
		busAccess(1'b1, shot, field, data, 1'b1, ignored);
		applyMotion((field == FIELD_Y || field == FIELD_CTRL) ? shot : -1);
		updateModel(shot, field, data);
	endtask

	task automatic drivePixel(input int px, input int py);
		@(negedge clk);
		pixelX = coord_t'(px);
		pixelY = coord_t'(py);
		curExp = {1'b1, expectPixel(px, py)};
	endtask

	// let the last two pixels drain before anything else changes
	task automatic endScan();
		@(negedge clk);
		curExp.valid = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	task automatic scanWindow(input int x0, input int y0, input int w, input int h);
		for (int py = y0; py < y0 + h; py++)
			for (int px = x0; px < x0 + w; px++)
				drivePixel(px, py);
		endScan();
	endtask

	task automatic scanRandom(input int count);
		int px;
		int py;
		repeat (count) begin
			px = nextRand() % 80;
			py = nextRand() % 64;
			drivePixel(px, py);
		end
		endScan();
	endtask

	// outputs lag the pixel by two cycles and settle before the falling edge
	initial begin : comparePixels
		pixelExp_t head;
		forever begin
			@(posedge clk);
			expQ.push_back(curExp); // pixel taken by this edge
			@(negedge clk);
			if (expQ.size() == 2) begin
				head = expQ.pop_front();
				if (head.valid) begin
					checkValue({testName, " request"}, 32'(head.req), 32'(shotsDrawingRequest));
					checkValue({testName, " rgb"}, 32'(head.rgb), 32'(shotsRGB));
				end
			end
		end
	end

	initial begin : watchdog
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("run stopped after %0d cycles, the tests did not finish", cycleCount);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		resetN = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatIn = '0;
		pixelX = '0;
		pixelY = '0;
		frameStart = 1'b0;
		for (int s = 0; s < `SHOT_COUNT; s++) begin
			mX[s] = '0;
			mY[s] = '0;
			mColor[s] = '0;
			mActive[s] = 1'b0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		resetN = 1'b1;
		checkValue("reset request", 32'h0, 32'(shotsDrawingRequest));
		checkValue("reset rgb", 32'h0, 32'(shotsRGB));
		checkValue("reset ack", 32'h0, 32'(wbAck));

		testName = "registers";
		for (int s = 0; s < `SHOT_COUNT; s++)
			for (int f = 0; f < 4; f++)
				readCheck(s, shotField_t'(f));
		for (int s = 0; s < `SHOT_COUNT; s++) begin
			wbWrite(s, FIELD_X, 16'hfc00 | 16'(s * 53 + 7)); // upper bits dropped
			wbWrite(s, FIELD_Y, 16'h8000 | 16'(s * 41 + 3));
			wbWrite(s, FIELD_COLOR, 16'hab00 | 16'(s * 29 + 1));
			wbWrite(s, FIELD_CTRL, 16'hfffe | 16'(s % 2));
		end
		for (int s = 0; s < `SHOT_COUNT; s++)
			for (int f = 0; f < 4; f++)
				readCheck(s, shotField_t'(f));
		for (int s = 0; s < `SHOT_COUNT; s++) begin
			wbWrite(s, FIELD_CTRL, 16'h0000);
			readCheck(s, FIELD_CTRL);
		end

		testName = "single shot";
		wbWrite(3, FIELD_X, 16'd300);
		wbWrite(3, FIELD_Y, 16'd200);
		wbWrite(3, FIELD_COLOR, 16'h001c);
		wbWrite(3, FIELD_CTRL, 16'h0001);
		scanWindow(296, 196, 16, 24);
		wbWrite(3, FIELD_CTRL, 16'h0000);

		testName = "priority";
		wbWrite(2, FIELD_X, 16'd200);
		wbWrite(2, FIELD_Y, 16'd100);
		wbWrite(2, FIELD_COLOR, 16'h0003);
		wbWrite(5, FIELD_X, 16'd202);
		wbWrite(5, FIELD_Y, 16'd104);
		wbWrite(5, FIELD_COLOR, 16'h0090);
		wbWrite(7, FIELD_X, 16'd201);
		wbWrite(7, FIELD_Y, 16'd102);
		wbWrite(7, FIELD_COLOR, 16'h0041);
		wbWrite(2, FIELD_CTRL, 16'h0001);
		wbWrite(5, FIELD_CTRL, 16'h0001);
		wbWrite(7, FIELD_CTRL, 16'h0001);
		scanWindow(198, 98, 12, 16);
		wbWrite(2, FIELD_CTRL, 16'h0000);
		wbWrite(5, FIELD_CTRL, 16'h0000);
		wbWrite(7, FIELD_CTRL, 16'h0000);

		testName = "motion";
		wbWrite(6, FIELD_X, 16'd100);
		wbWrite(6, FIELD_Y, 16'd18); // retires on the fifth frame
		wbWrite(6, FIELD_COLOR, 16'h00e0);
		wbWrite(6, FIELD_CTRL, 16'h0001);
		scanWindow(98, 0, 8, 28);
		repeat (5) begin
			framePulse();
			readCheck(6, FIELD_Y);
			readCheck(6, FIELD_CTRL);
			scanWindow(98, 0, 8, 28);
		end

		testName = "write on frame edge";
		wbWrite(6, FIELD_Y, 16'd60);
		wbWrite(6, FIELD_CTRL, 16'h0001);
		frameWithWrite(6, FIELD_Y, 16'd30);
		readCheck(6, FIELD_Y);
		framePulse();
		readCheck(6, FIELD_Y);
		frameWithWrite(6, FIELD_CTRL, 16'h0000); // y must stay put
		readCheck(6, FIELD_Y);
		readCheck(6, FIELD_CTRL);

		testName = "random scenes";
		repeat (4) begin
			for (int s = 0; s < `SHOT_COUNT; s++) begin
				wbWrite(s, FIELD_X, 16'(nextRand() % 64 + 8));
				wbWrite(s, FIELD_Y, 16'(nextRand() % 56));
				wbWrite(s, FIELD_COLOR, nextRand());
				wbWrite(s, FIELD_CTRL, nextRand() >> 3);
			end
			scanRandom(250);
		end

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== source/shotsTop.sv ====
`include "shots_settings.svh"

module shotsTop (
	input	logic	clk,
	input	logic	resetN,

	// wishbone classic slave from the CPU
	input	logic	wbCyc,
	input	logic	wbStb,
	input	logic	wbWe,
	input	logic	[`WB_ADR_BITS-1:0] wbAdr,
	input	logic	[`WB_DAT_BITS-1:0] wbDatIn,
	output	logic	[`WB_DAT_BITS-1:0] wbDatOut,
	output	logic	wbAck,

	// from the video controller
	input	shotsPkg::coord_t	pixelX,
	input	shotsPkg::coord_t	pixelY,
	input	logic	frameStart,

	// to the layer mux, two cycles after the pixel
	output	logic	shotsDrawingRequest,
	output	shotsPkg::rgb_t	shotsRGB
);

	import shotsPkg::*;

	// shared write port
	logic	[`SHOT_COUNT-1:0] wrEn;
	shotField_t	wrField;
	logic	[`WB_DAT_BITS-1:0] wrData;

	// per shot readback
	coord_t	shotX [`SHOT_COUNT];
	coord_t	shotY [`SHOT_COUNT];
	rgb_t	shotColor [`SHOT_COUNT];
	logic	[`SHOT_COUNT-1:0] shotActive;

	// per shot drawing request
	logic	[`SHOT_COUNT-1:0] shotRequest;
	rgb_t	shotRGB [`SHOT_COUNT];

	shotsRegs regs_i (
		.clk(clk),
		.resetN(resetN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.wbDatOut(wbDatOut),
		.wrEn(wrEn),
		.wrField(wrField),
		.wrData(wrData),
		.shotX(shotX),
		.shotY(shotY),
		.shotColor(shotColor),
		.shotActive(shotActive)
	);

	for (genvar i = 0; i < `SHOT_COUNT; i++) begin : gShot
		shotObject shot_i (
			.clk(clk),
			.resetN(resetN),
			.wrEn(wrEn[i]), // own strobe, shared field and data
			.wrField(wrField),
			.wrData(wrData),
			.frameStart(frameStart),
			.pixelX(pixelX),
			.pixelY(pixelY),
			.x(shotX[i]),
			.y(shotY[i]),
			.color(shotColor[i]),
			.active(shotActive[i]),
			.drawingRequest(shotRequest[i]),
			.rgb(shotRGB[i])
		);
	end

	shotsMux mux_i (
		.clk(clk),
		.resetN(resetN),
		.shotRequest(shotRequest),
		.shotRGB(shotRGB),
		.shotsDrawingRequest(shotsDrawingRequest),
		.shotsRGB(shotsRGB)
	);

endmodule

// ==== shots/shotsMux.sv ====
`include "shots_settings.svh"

module shotsMux (
	input	logic	clk,
	input	logic	resetN,

	// one request bit and one colour per shot
	input	logic	[`SHOT_COUNT-1:0] shotRequest,
	input	shotsPkg::rgb_t	shotRGB [`SHOT_COUNT],

	// merged result, one cycle behind the requests
	output	logic	shotsDrawingRequest,
	output	shotsPkg::rgb_t	shotsRGB
);

	import shotsPkg::*;

	rgb_t	winnerRGB;
	logic	anyRequest;

	// walk from the highest index down so shot 0 overrides everyone
	always_comb begin
		winnerRGB = `TRANSPARENT_RGB; // nothing covers the pixel
		for (int i = `SHOT_COUNT - 1; i >= 0; i--) begin
			if (shotRequest[i])
				winnerRGB = shotRGB[i];
		end
	end

	assign anyRequest = |shotRequest;

	// request and colour registered together so they stay aligned
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			shotsDrawingRequest <= 1'b0;
			shotsRGB <= 8'h00;
		end
		else begin
			shotsDrawingRequest <= anyRequest;
			shotsRGB <= winnerRGB;
		end
	end

endmodule

// ==== shots/shotObject.sv ====
`include "shots_settings.svh"

module shotObject (
	input	logic	clk,
	input	logic	resetN,

	// register write port
	input	logic	wrEn,
	input	shotsPkg::shotField_t	wrField,
	input	logic	[`WB_DAT_BITS-1:0] wrData,

	// video timing
	input	logic	frameStart,
	input	shotsPkg::coord_t	pixelX,
	input	shotsPkg::coord_t	pixelY,

	// stored fields, read back through the register port
	output	shotsPkg::coord_t	x,
	output	shotsPkg::coord_t	y,
	output	shotsPkg::rgb_t	color,
	output	logic	active,

	// drawing request towards the mux
	output	logic	drawingRequest,
	output	shotsPkg::rgb_t	rgb
);

	import shotsPkg::*;

	localparam int CW = $bits(coord_t);
	localparam int RW = $bits(rgb_t);

	logic	wrOverride;
	logic	climb;
	logic	retire;
	logic	[CW:0] xEnd;
	logic	[CW:0] yEnd;
	logic	insideX;
	logic	insideY;

	// a y or ctrl write on the frame edge beats the motion
	assign wrOverride = wrEn && (wrField == FIELD_Y || wrField == FIELD_CTRL);

	assign climb = frameStart && active && !wrOverride && (y >= `SHOT_SPEED);
	assign retire = frameStart && active && !wrOverride && (y < `SHOT_SPEED); // would leave the top

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			x <= '0;
			y <= '0;
			color <= '0;
			active <= 1'b0;
		end
		else begin
			if (climb)
				y <= y - `SHOT_SPEED;
			if (retire)
				active <= 1'b0;

			if (wrEn) begin
				case (wrField)
					FIELD_X:     x <= wrData[CW-1:0];
					FIELD_Y:     y <= wrData[CW-1:0];
					FIELD_COLOR: color <= wrData[RW-1:0];
					FIELD_CTRL:  active <= wrData[0];
					default:     active <= active;
				endcase
			end
		end
	end

	// one extra bit so the right and bottom edges never wrap
	assign xEnd = {1'b0, x} + `SHOT_WIDTH;
	assign yEnd = {1'b0, y} + `SHOT_HEIGHT;

	assign insideX = (pixelX >= x) && ({1'b0, pixelX} < xEnd);
	assign insideY = (pixelY >= y) && ({1'b0, pixelY} < yEnd);

	// hit is registered, one cycle after the pixel arrives
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			drawingRequest <= 1'b0;
		else
			drawingRequest <= active && insideX && insideY;
	end

	assign rgb = color; // colour only changes on register writes

endmodule

// ==== source/shotsRegs.sv ====
`include "shots_settings.svh"

module shotsRegs (
	input	logic	clk,
	input	logic	resetN,

	// wishbone classic slave
	input	logic	wbCyc,
	input	logic	wbStb,
	input	logic	wbWe,
	input	logic	[`WB_ADR_BITS-1:0] wbAdr,
	input	logic	[`WB_DAT_BITS-1:0] wbDatIn,
	output	logic	wbAck,
	output	logic	[`WB_DAT_BITS-1:0] wbDatOut,

	// write port shared by all shots
	output	logic	[`SHOT_COUNT-1:0] wrEn,
	output	shotsPkg::shotField_t	wrField,
	output	logic	[`WB_DAT_BITS-1:0] wrData,

	// current field values of every shot
	input	shotsPkg::coord_t	shotX [`SHOT_COUNT],
	input	shotsPkg::coord_t	shotY [`SHOT_COUNT],
	input	shotsPkg::rgb_t	shotColor [`SHOT_COUNT],
	input	logic	[`SHOT_COUNT-1:0] shotActive
);

	import shotsPkg::*;

	localparam int DW = `WB_DAT_BITS;
	localparam int IW = `SHOT_INDEX_BITS;

	logic	access;
	logic	[IW-1:0] shotIdx;
	shotField_t	field;
	logic	[DW-1:0] readData;

	// a new bus cycle that has not been acked yet
	assign access = wbCyc && wbStb && !wbAck;

	// address split: upper bits pick the shot, lower bits the field
	assign shotIdx = wbAdr[`WB_ADR_BITS-1 -: IW];
	assign field = shotField_t'(wbAdr[1:0]);

	// write strobe lands on the same edge that raises the ack
	always_comb begin
		wrEn = '0;
		if (access && wbWe)
			wrEn[shotIdx] = 1'b1; // addressed shot only
	end

	assign wrField = field; // shared by all shots
	assign wrData = wbDatIn;

	// readback mux, fields are zero extended to the bus width
	always_comb begin
		case (field)
			FIELD_X:
				readData = DW'(shotX[shotIdx]);
			FIELD_Y:
				readData = DW'(shotY[shotIdx]);
			FIELD_COLOR:
				readData = DW'(shotColor[shotIdx]);
			FIELD_CTRL:
				readData = DW'(shotActive[shotIdx]); // active flag in bit 0
			default:
				readData = '0;
		endcase
	end

	// single cycle ack, drops by itself while stb is still high
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			wbAck <= 1'b0;
		else
			wbAck <= access;
	end

	// read data is valid while ack is high
	always_ff @(posedge clk) begin
		if (access && !wbWe)
			wbDatOut <= readData;
	end

endmodule

// ==== common/shotsPkg.sv ====
package shotsPkg;

	// screen coordinate, wide enough for 640x480 and some margin
	typedef logic [9:0] coord_t;

	// pixel colour, 3 bits red, 3 bits green, 2 bits blue
	typedef logic [7:0] rgb_t;

	// register field selected by the two low address bits
	typedef enum logic [1:0] {
		FIELD_X     = 2'd0, // left edge of the shot
		FIELD_Y     = 2'd1, // top edge of the shot
		FIELD_COLOR = 2'd2, // drawing colour
		FIELD_CTRL  = 2'd3  // bit 0 is the active flag
	} shotField_t;

endpackage

// ==== common/shots_settings.svh ====
`ifndef SHOTS_SETTINGS_SVH
`define SHOTS_SETTINGS_SVH

// number of shots on screen
`define SHOT_COUNT 8

// shot rectangle size in pixels
`define SHOT_WIDTH 10'd4
`define SHOT_HEIGHT 10'd8

// upward step applied on every frame start
`define SHOT_SPEED 10'd4

// colour reported when no shot covers the pixel
`define TRANSPARENT_RGB 8'hff

// wishbone register port
`define WB_ADR_BITS 5
`define WB_DAT_BITS 16
`define SHOT_INDEX_BITS 3

`endif
